// File: src/mem_port_pkg.sv
/*
 * shared types for the memory-port combiner
 * widths, source codes, channel structs, bus bundles, arbitration mode
 */
package mem_port_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  id_t;
  typedef logic [3:0]  len_t;
  typedef logic [1:0]  src_t;
  typedef logic [1:0]  resp_t;
  typedef logic [1:0]  cfg_addr_t;

  // ------------------------------------------------------------
  // client indices and id source field
  // ------------------------------------------------------------
  localparam int unsigned NUM_CLIENTS = 3;

  localparam src_t SRC_FETCH  = 2'd0;
  localparam src_t SRC_BYPASS = 2'd1;
  localparam src_t SRC_DATA   = 2'd2;

  // id bits 3..2
  localparam logic [1:0] ID_SRC_FETCH  = 2'b00;
  localparam logic [1:0] ID_SRC_BYPASS = 2'b10;
  localparam logic [1:0] ID_SRC_DATA   = 2'b11;

  // ------------------------------------------------------------
  // channel payloads
  // ------------------------------------------------------------
  // shared by ar and aw
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } addr_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } wdat_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } rdat_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } wrsp_chan_t;

  // ------------------------------------------------------------
  // bus bundles
  // ------------------------------------------------------------
  // master to slave
  typedef struct packed {
    addr_chan_t ar;
    logic       ar_valid;
    addr_chan_t aw;
    logic       aw_valid;
    wdat_chan_t w;
    logic       w_valid;
    logic       r_ready;
    logic       b_ready;
  } mem_req_t;

  // slave to master
  typedef struct packed {
    logic       ar_ready;
    logic       aw_ready;
    logic       w_ready;
    rdat_chan_t r;
    logic       r_valid;
    wrsp_chan_t b;
    logic       b_valid;
  } mem_rsp_t;

  typedef enum logic {
    ARB_FIXED       = 1'b0,
    ARB_ROUND_ROBIN = 1'b1
  } arb_mode_e;

endpackage

// File: src/port_cfg_regs.sv
/*
 * configuration registers on a four-phase req/ack port
 * enable mask at address 0, arbitration mode at address 1
 */
`timescale 1ns/10ps

module port_cfg_regs (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   cfg_req_i,
  input  logic                                   cfg_we_i,
  input  mem_port_pkg::cfg_addr_t                cfg_addr_i,
  input  mem_port_pkg::data_t                    cfg_wdata_i,
  output logic                                   cfg_ack_o,
  output mem_port_pkg::data_t                    cfg_rdata_o,
  output logic [mem_port_pkg::NUM_CLIENTS-1:0]   en_mask_o,
  output mem_port_pkg::arb_mode_e                arb_mode_o
);

  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_e;

  cfg_state_e          state_q;
  logic                access;
  mem_port_pkg::data_t rdata_d;
  mem_port_pkg::data_t rdata_q;

  // one access per request, taken on the first edge with req high
  assign access = (state_q == CFG_IDLE) && cfg_req_i;

  always_comb begin
    case (cfg_addr_i)
      2'd0:    rdata_d = mem_port_pkg::data_t'(en_mask_o);
      2'd1:    rdata_d = mem_port_pkg::data_t'(arb_mode_o);
      default: rdata_d = '0;
    endcase
  end

  // ------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= CFG_IDLE;
    end else begin
      case (state_q)
        CFG_IDLE: if (cfg_req_i) state_q <= CFG_ACK;
        CFG_ACK:  if (!cfg_req_i) state_q <= CFG_IDLE;
        default:  state_q <= CFG_IDLE;
      endcase
    end
  end

  assign cfg_ack_o = (state_q == CFG_ACK);

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_mask_o  <= '1;
      arb_mode_o <= mem_port_pkg::ARB_FIXED;
    end else if (access && cfg_we_i) begin
      if (cfg_addr_i == 2'd0) en_mask_o <= cfg_wdata_i[mem_port_pkg::NUM_CLIENTS-1:0];
      if (cfg_addr_i == 2'd1) arb_mode_o <= mem_port_pkg::arb_mode_e'(cfg_wdata_i[0]);
    end
  end

  // read data held for the whole ack phase
  always_ff @(posedge clk_i) begin
    if (access) rdata_q <= rdata_d;
  end

  assign cfg_rdata_o = rdata_q;

endmodule

// File: src/addr_arbiter.sv
/*
 * valid/ready arbiter for one address channel
 * fixed priority or round robin, enable mask, grant lock under back-pressure
 */
`timescale 1ns/10ps

module addr_arbiter #(
  parameter int unsigned NumInp = 3
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  mem_port_pkg::addr_chan_t  inp_chan_i [NumInp],
  input  logic [NumInp-1:0]         inp_valid_i,
  output logic [NumInp-1:0]         inp_ready_o,
  input  logic [NumInp-1:0]         en_mask_i,
  input  mem_port_pkg::arb_mode_e   arb_mode_i,
  input  logic                      hold_i,
  output mem_port_pkg::addr_chan_t  out_chan_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output mem_port_pkg::src_t        gnt_idx_o,
  output logic                      gnt_o
);

  logic [NumInp-1:0]  req;
  mem_port_pkg::src_t pick;
  mem_port_pkg::src_t sel;
  mem_port_pkg::src_t lock_idx_q;
  mem_port_pkg::src_t rr_q;
  logic               locked_q;

  assign req = inp_valid_i & en_mask_i;

  // ------------------------------------------------------------
  // choice of the next client
  // ------------------------------------------------------------
  always_comb begin
    int cand;
    pick = '0;
    cand = 0;
    if (arb_mode_i == mem_port_pkg::ARB_ROUND_ROBIN) begin
      // walk backwards so the client right after the last grant wins
      for (int off = NumInp; off >= 1; off--) begin
        cand = int'(rr_q) + off;
        if (cand >= NumInp) cand = cand - NumInp;
        if (req[cand]) pick = mem_port_pkg::src_t'(cand);
      end
    end else begin
      // highest index wins, i.e. data, bypass, fetch
      for (int i = 0; i < NumInp; i++) begin
        if (req[i]) pick = mem_port_pkg::src_t'(i);
      end
    end
  end

  // a stalled request keeps its slot even if the mask changes
  assign sel         = locked_q ? lock_idx_q : pick;
  assign out_valid_o = !hold_i && (locked_q ? inp_valid_i[lock_idx_q] : |req);
  assign out_chan_o  = inp_chan_i[sel];
  assign gnt_idx_o   = sel;
  assign gnt_o       = out_valid_o && out_ready_i;

  for (genvar i = 0; i < NumInp; i++) begin : g_ready
    assign inp_ready_o[i] = gnt_o && (sel == mem_port_pkg::src_t'(i));
  end

  // ------------------------------------------------------------
  // lock and round-robin pointer
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
      // first round-robin search starts at client 0
      rr_q       <= mem_port_pkg::src_t'(NumInp - 1);
    end else begin
      locked_q   <= out_valid_o && !out_ready_i;
      lock_idx_q <= sel;
      if (gnt_o) rr_q <= sel;
    end
  end

endmodule

// File: src/wdata_order_fifo.sv
/*
 * order FIFO of granted write sources
 * head steers the write-data multiplexer, last beat pops
 */
`timescale 1ns/10ps

module wdata_order_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   push_i,
  input  mem_port_pkg::src_t                     push_idx_i,
  output logic                                   full_o,
  input  mem_port_pkg::wdat_chan_t               client_w_i [mem_port_pkg::NUM_CLIENTS],
  input  logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_w_valid_i,
  output logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_w_ready_o,
  output mem_port_pkg::wdat_chan_t               bus_w_o,
  output logic                                   bus_w_valid_o,
  input  logic                                   bus_w_ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;

  mem_port_pkg::src_t idx_mem [Depth];
  ptr_t               wr_ptr_q;
  ptr_t               rd_ptr_q;
  logic [CntW-1:0]    count_q;
  mem_port_pkg::src_t head;
  logic               empty;
  logic               pop;

  function automatic ptr_t ptr_next(ptr_t p);
    return (p == ptr_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty  = (count_q == '0);
  assign full_o = (count_q == CntW'(Depth));
  assign head   = idx_mem[rd_ptr_q];

  // ------------------------------------------------------------
  // write data path
  // ------------------------------------------------------------
  assign bus_w_o       = client_w_i[head];
  assign bus_w_valid_o = !empty && client_w_valid_i[head];
  assign pop           = bus_w_valid_o && bus_w_ready_i && bus_w_o.last;

  for (genvar i = 0; i < mem_port_pkg::NUM_CLIENTS; i++) begin : g_ready
    assign client_w_ready_o[i] = !empty && bus_w_ready_i &&
                                 (head == mem_port_pkg::src_t'(i));
  end

  // ------------------------------------------------------------
  // pointers and count
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)    rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) idx_mem[wr_ptr_q] <= push_idx_i;
  end

endmodule

// File: src/rsp_router.sv
/*
 * R and B response routing by id source field
 * payload broadcast, valid and ready steered
 */
`timescale 1ns/10ps

module rsp_router (
  input  mem_port_pkg::rdat_chan_t               bus_r_i,
  input  logic                                   bus_r_valid_i,
  output logic                                   bus_r_ready_o,
  input  mem_port_pkg::wrsp_chan_t               bus_b_i,
  input  logic                                   bus_b_valid_i,
  output logic                                   bus_b_ready_o,
  output mem_port_pkg::rdat_chan_t               client_r_o [mem_port_pkg::NUM_CLIENTS],
  output logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_r_valid_o,
  input  logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_r_ready_i,
  output mem_port_pkg::wrsp_chan_t               client_b_o [mem_port_pkg::NUM_CLIENTS],
  output logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_b_valid_o,
  input  logic [mem_port_pkg::NUM_CLIENTS-1:0]   client_b_ready_i
);

  mem_port_pkg::src_t r_sel;
  mem_port_pkg::src_t b_sel;

  // id bits 3..2 to client index, unknown codes go to fetch
  function automatic mem_port_pkg::src_t src_of(mem_port_pkg::id_t id);
    case (id[3:2])
      mem_port_pkg::ID_SRC_DATA:   return mem_port_pkg::SRC_DATA;
      mem_port_pkg::ID_SRC_BYPASS: return mem_port_pkg::SRC_BYPASS;
      mem_port_pkg::ID_SRC_FETCH:  return mem_port_pkg::SRC_FETCH;
      default:                     return mem_port_pkg::SRC_FETCH;
    endcase
  endfunction

  assign r_sel = src_of(bus_r_i.id);
  assign b_sel = src_of(bus_b_i.id);

  assign bus_r_ready_o = client_r_ready_i[r_sel];
  assign bus_b_ready_o = client_b_ready_i[b_sel];

  for (genvar i = 0; i < mem_port_pkg::NUM_CLIENTS; i++) begin : g_client
    assign client_r_o[i]       = bus_r_i;
    assign client_r_valid_o[i] = bus_r_valid_i && (r_sel == mem_port_pkg::src_t'(i));
    assign client_b_o[i]       = bus_b_i;
    assign client_b_valid_o[i] = bus_b_valid_i && (b_sel == mem_port_pkg::src_t'(i));
  end

endmodule

// File: src/mem_port_mux.sv
/*
 * memory-port combiner top level
 * config block, AR and AW arbiters, write ordering, response routing
 */
`timescale 1ns/10ps

module mem_port_mux #(
  parameter int unsigned WrDepth = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     cfg_req_i,
  input  logic                     cfg_we_i,
  input  mem_port_pkg::cfg_addr_t  cfg_addr_i,
  input  mem_port_pkg::data_t      cfg_wdata_i,
  output logic                     cfg_ack_o,
  output mem_port_pkg::data_t      cfg_rdata_o,
  input  mem_port_pkg::mem_req_t   client_req_i [mem_port_pkg::NUM_CLIENTS],
  output mem_port_pkg::mem_rsp_t   client_rsp_o [mem_port_pkg::NUM_CLIENTS],
  output mem_port_pkg::mem_req_t   bus_req_o,
  input  mem_port_pkg::mem_rsp_t   bus_rsp_i
);

  localparam int unsigned NC = mem_port_pkg::NUM_CLIENTS;

  logic [NC-1:0]             en_mask;
  mem_port_pkg::arb_mode_e   arb_mode;

  mem_port_pkg::addr_chan_t  ar_chan [NC];
  logic [NC-1:0]             ar_valid;
  logic [NC-1:0]             ar_ready;
  mem_port_pkg::addr_chan_t  aw_chan [NC];
  logic [NC-1:0]             aw_valid;
  logic [NC-1:0]             aw_ready;
  mem_port_pkg::wdat_chan_t  w_chan [NC];
  logic [NC-1:0]             w_valid;
  logic [NC-1:0]             w_ready;
  mem_port_pkg::rdat_chan_t  r_chan [NC];
  logic [NC-1:0]             r_valid;
  logic [NC-1:0]             r_ready;
  mem_port_pkg::wrsp_chan_t  b_chan [NC];
  logic [NC-1:0]             b_valid;
  logic [NC-1:0]             b_ready;

  mem_port_pkg::src_t        aw_gnt_idx;
  logic                      aw_gnt;
  logic                      wr_full;

  // ------------------------------------------------------------
  // client bundles split per channel
  // ------------------------------------------------------------
  for (genvar i = 0; i < NC; i++) begin : g_client
    assign ar_chan[i]  = client_req_i[i].ar;
    assign ar_valid[i] = client_req_i[i].ar_valid;
    assign aw_chan[i]  = client_req_i[i].aw;
    assign aw_valid[i] = client_req_i[i].aw_valid;
    assign w_chan[i]   = client_req_i[i].w;
    assign w_valid[i]  = client_req_i[i].w_valid;
    assign r_ready[i]  = client_req_i[i].r_ready;
    assign b_ready[i]  = client_req_i[i].b_ready;

    assign client_rsp_o[i].ar_ready = ar_ready[i];
    assign client_rsp_o[i].aw_ready = aw_ready[i];
    assign client_rsp_o[i].w_ready  = w_ready[i];
    assign client_rsp_o[i].r        = r_chan[i];
    assign client_rsp_o[i].r_valid  = r_valid[i];
    assign client_rsp_o[i].b        = b_chan[i];
    assign client_rsp_o[i].b_valid  = b_valid[i];
  end

  port_cfg_regs i_cfg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_req_i   (cfg_req_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_ack_o   (cfg_ack_o),
    .cfg_rdata_o (cfg_rdata_o),
    .en_mask_o   (en_mask),
    .arb_mode_o  (arb_mode)
  );

  // ------------------------------------------------------------
  // address channels
  // ------------------------------------------------------------
  addr_arbiter #(
    .NumInp (NC)
  ) i_ar_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .inp_chan_i  (ar_chan),
    .inp_valid_i (ar_valid),
    .inp_ready_o (ar_ready),
    .en_mask_i   (en_mask),
    .arb_mode_i  (arb_mode),
    .hold_i      (1'b0),
    .out_chan_o  (bus_req_o.ar),
    .out_valid_o (bus_req_o.ar_valid),
    .out_ready_i (bus_rsp_i.ar_ready),
    .gnt_idx_o   (),
    .gnt_o       ()
  );

  // no new write address while the order FIFO is full
  addr_arbiter #(
    .NumInp (NC)
  ) i_aw_arb (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .inp_chan_i  (aw_chan),
    .inp_valid_i (aw_valid),
    .inp_ready_o (aw_ready),
    .en_mask_i   (en_mask),
    .arb_mode_i  (arb_mode),
    .hold_i      (wr_full),
    .out_chan_o  (bus_req_o.aw),
    .out_valid_o (bus_req_o.aw_valid),
    .out_ready_i (bus_rsp_i.aw_ready),
    .gnt_idx_o   (aw_gnt_idx),
    .gnt_o       (aw_gnt)
  );

  // write data follows aw grant order, the bus has no write-data id
  wdata_order_fifo #(
    .Depth (WrDepth)
  ) i_w_order (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .push_i           (aw_gnt),
    .push_idx_i       (aw_gnt_idx),
    .full_o           (wr_full),
    .client_w_i       (w_chan),
    .client_w_valid_i (w_valid),
    .client_w_ready_o (w_ready),
    .bus_w_o          (bus_req_o.w),
    .bus_w_valid_o    (bus_req_o.w_valid),
    .bus_w_ready_i    (bus_rsp_i.w_ready)
  );

  rsp_router i_rsp (
    .bus_r_i          (bus_rsp_i.r),
    .bus_r_valid_i    (bus_rsp_i.r_valid),
    .bus_r_ready_o    (bus_req_o.r_ready),
    .bus_b_i          (bus_rsp_i.b),
    .bus_b_valid_i    (bus_rsp_i.b_valid),
    .bus_b_ready_o    (bus_req_o.b_ready),
    .client_r_o       (r_chan),
    .client_r_valid_o (r_valid),
    .client_r_ready_i (r_ready),
    .client_b_o       (b_chan),
    .client_b_valid_o (b_valid),
    .client_b_ready_i (b_ready)
  );

endmodule

// File: test/tb_mem_port_mux.sv
/*
 * testbench for the memory-port combiner
 * client drivers, bus memory model, scoreboards, watchdog
 */
`timescale 1ns/10ps

module tb_mem_port_mux;

  localparam int unsigned NC        = mem_port_pkg::NUM_CLIENTS;
  localparam int          RAND_OPS  = 30;
  localparam int          MAX_LEN   = 7;
  // transactions, cycles per burst with stalls, margin
  localparam longint      NUM_TXN   = 3 * RAND_OPS + 30;
  localparam longint      BURST_CYC = (MAX_LEN + 1) * 4;
  localparam longint      TIMEOUT   = NUM_TXN * BURST_CYC * 4 * 20;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       cfg_req;
  logic                       cfg_we;
  mem_port_pkg::cfg_addr_t    cfg_addr;
  mem_port_pkg::data_t        cfg_wdata;
  logic                       cfg_ack;
  mem_port_pkg::data_t        cfg_rdata;
  mem_port_pkg::mem_req_t     client_req [NC];
  mem_port_pkg::mem_rsp_t     client_rsp [NC];
  mem_port_pkg::mem_req_t     bus_req;
  mem_port_pkg::mem_rsp_t     bus_rsp;

  // scoreboards
  mem_port_pkg::addr_chan_t   rexp [NC][$];
  mem_port_pkg::id_t          bexp [NC][$];
  mem_port_pkg::data_t        wexp [NC][$];
  mem_port_pkg::addr_chan_t   awexp [NC][$];
  int                         rbeat [NC];
  // memory model state
  mem_port_pkg::addr_chan_t   ar_q[$];
  mem_port_pkg::addr_chan_t   aw_pend[$];
  mem_port_pkg::id_t          b_q[$];
  int                         ar_log[$];
  int                         mem_rbeat;
  int                         mem_wbeat;
  logic [NC-1:0]              tb_mask;
  logic                       stall_en;
  int                         n_checks;
  int                         n_err;

  // two entries so that three writers can fill the order FIFO
  mem_port_mux #(
    .WrDepth (2)
  ) dut_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cfg_req_i    (cfg_req),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_ack_o    (cfg_ack),
    .cfg_rdata_o  (cfg_rdata),
    .client_req_i (client_req),
    .client_rsp_o (client_rsp),
    .bus_req_o    (bus_req),
    .bus_rsp_i    (bus_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT);
    $display("ERROR: run did not finish within %0d ns", TIMEOUT);
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------------------
  // checking helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_err++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    n_err++;
    $display("ERROR: %s", msg);
  endtask

  // id source codes 00 fetch, 10 bypass, 11 data
  function automatic logic [1:0] code_of_client(input int c);
    case (c)
      1:       return 2'b10;
      2:       return 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  function automatic int client_of_id(input mem_port_pkg::id_t id);
    if (id[3:2] == 2'b11) return 2;
    if (id[3:2] == 2'b10) return 1;
    return 0;
  endfunction

  // ------------------------------------------------------------
  // bus memory model
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    bus_rsp.ar_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    bus_rsp.aw_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
    bus_rsp.w_ready  = stall_en ? ($urandom % 4 != 0) : 1'b1;
    bus_rsp.r_valid  = (ar_q.size() > 0);
    if (ar_q.size() > 0) begin
      bus_rsp.r.id   = ar_q[0].id;
      bus_rsp.r.data = ar_q[0].addr + mem_port_pkg::data_t'(mem_rbeat);
      bus_rsp.r.last = (mem_rbeat == int'(ar_q[0].len));
    end
    bus_rsp.b_valid = (b_q.size() > 0);
    if (b_q.size() > 0) begin
      bus_rsp.b.id   = b_q[0];
      // response code taken from the low id bits
      bus_rsp.b.resp = mem_port_pkg::resp_t'(b_q[0][1:0]);
    end
  end

  // client side back-pressure on R and B
  always @(negedge clk_i) begin
    if (stall_en) begin
      for (int c = 0; c < NC; c++) begin
        client_req[c].r_ready = ($urandom % 4 != 0);
        client_req[c].b_ready = ($urandom % 4 != 0);
      end
    end
  end

  always @(posedge clk_i) begin
    int src;
    mem_port_pkg::addr_chan_t e;
    if (arst_n_i) begin
      if (bus_req.ar_valid && bus_rsp.ar_ready) begin
        src = client_of_id(bus_req.ar.id);
        if (!tb_mask[src]) report_error($sformatf("AR from disabled client %0d", src));
        ar_q.push_back(bus_req.ar);
        ar_log.push_back(src);
      end
      if (bus_req.aw_valid && bus_rsp.aw_ready) begin
        src = client_of_id(bus_req.aw.id);
        if (!tb_mask[src]) report_error($sformatf("AW from disabled client %0d", src));
        if (awexp[src].size() == 0) begin
          report_error($sformatf("AW for client %0d that sent no write", src));
        end else begin
          e = awexp[src].pop_front();
          check_value("aw id", 32'(e.id), 32'(bus_req.aw.id));
          check_value("aw addr", e.addr, bus_req.aw.addr);
          check_value("aw len", 32'(e.len), 32'(bus_req.aw.len));
        end
        aw_pend.push_back(bus_req.aw);
      end
      if (bus_req.w_valid && bus_rsp.w_ready) begin
        if (aw_pend.size() == 0) begin
          report_error("W beat on the bus without a granted AW");
        end else begin
          src = client_of_id(aw_pend[0].id);
          if (wexp[src].size() == 0) begin
            report_error($sformatf("W beat for client %0d with no data sent", src));
          end else begin
            check_value("w data order", wexp[src].pop_front(), bus_req.w.data);
          end
          check_value("w last", 32'(mem_wbeat == int'(aw_pend[0].len)), 32'(bus_req.w.last));
          if (bus_req.w.last) begin
            b_q.push_back(aw_pend[0].id);
            void'(aw_pend.pop_front());
            mem_wbeat = 0;
          end else begin
            mem_wbeat++;
          end
        end
      end
      if (bus_rsp.r_valid && bus_req.r_ready) begin
        if (bus_rsp.r.last) begin
          void'(ar_q.pop_front());
          mem_rbeat = 0;
        end else begin
          mem_rbeat++;
        end
      end
      if (bus_rsp.b_valid && bus_req.b_ready) void'(b_q.pop_front());
    end
  end

  // client side response checks
  always @(posedge clk_i) begin
    mem_port_pkg::addr_chan_t e;
    mem_port_pkg::id_t        bid;
    for (int c = 0; c < NC; c++) begin
      if (arst_n_i && client_rsp[c].r_valid && client_req[c].r_ready) begin
        if (rexp[c].size() == 0) begin
          report_error($sformatf("unexpected R beat at client %0d", c));
        end else begin
          e = rexp[c][0];
          check_value("r id", 32'(e.id), 32'(client_rsp[c].r.id));
          check_value("r data", e.addr + 32'(rbeat[c]), client_rsp[c].r.data);
          check_value("r last", 32'(rbeat[c] == int'(e.len)), 32'(client_rsp[c].r.last));
          if (rbeat[c] == int'(e.len)) begin
            void'(rexp[c].pop_front());
            rbeat[c] = 0;
          end else begin
            rbeat[c]++;
          end
        end
      end
      if (arst_n_i && client_rsp[c].b_valid && client_req[c].b_ready) begin
        if (bexp[c].size() == 0) begin
          report_error($sformatf("unexpected B at client %0d", c));
        end else begin
          bid = bexp[c].pop_front();
          check_value("b id", 32'(bid), 32'(client_rsp[c].b.id));
          check_value("b resp", 32'(bid[1:0]), 32'(client_rsp[c].b.resp));
        end
      end
    end
  end

  // ------------------------------------------------------------
  // client drivers
  // ------------------------------------------------------------
  function automatic mem_port_pkg::addr_chan_t make_chan(input int c, input int len);
    mem_port_pkg::addr_chan_t a;
    a.id   = {code_of_client(c), 2'($urandom % 4)};
    a.addr = $urandom & 32'hffff_fffc;
    a.len  = mem_port_pkg::len_t'(len);
    return a;
  endfunction

  task automatic do_read(input int c, input int len, input bit keep);
    mem_port_pkg::addr_chan_t a;
    a = make_chan(c, len);
    @(negedge clk_i);
    client_req[c].ar       = a;
    client_req[c].ar_valid = 1'b1;
    do @(posedge clk_i); while (!client_rsp[c].ar_ready);
    rexp[c].push_back(a);
    if (!keep) begin
      @(negedge clk_i);
      client_req[c].ar_valid = 1'b0;
    end
  endtask

  task automatic do_write(input int c, input int len);
    mem_port_pkg::addr_chan_t a;
    mem_port_pkg::data_t      d;
    a = make_chan(c, len);
    awexp[c].push_back(a);
    @(negedge clk_i);
    client_req[c].aw       = a;
    client_req[c].aw_valid = 1'b1;
    do @(posedge clk_i); while (!client_rsp[c].aw_ready);
    bexp[c].push_back(a.id);
    @(negedge clk_i);
    client_req[c].aw_valid = 1'b0;
    for (int b = 0; b <= len; b++) begin
      d = $urandom;
      wexp[c].push_back(d);
      client_req[c].w.data = d;
      client_req[c].w.last = (b == len);
      client_req[c].w_valid = 1'b1;
      do @(posedge clk_i); while (!client_rsp[c].w_ready);
      @(negedge clk_i);
    end
    client_req[c].w_valid = 1'b0;
  endtask

  task automatic run_client(input int c, input int n);
    repeat (n) begin
      if ($urandom % 2 == 0) do_read(c, int'($urandom % (MAX_LEN + 1)), 1'b0);
      else                   do_write(c, int'($urandom % (MAX_LEN + 1)));
    end
  endtask

  // ------------------------------------------------------------
  // configuration port
  // ------------------------------------------------------------
  task automatic cfg_access(input logic we, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(negedge clk_i);
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = mem_port_pkg::cfg_addr_t'(addr);
    cfg_wdata = wdata;
    @(negedge clk_i);
    check_value("cfg ack rise", 32'h1, 32'(cfg_ack));
    rdata   = cfg_rdata;
    cfg_req = 1'b0;
    @(negedge clk_i);
    check_value("cfg ack fall", 32'h0, 32'(cfg_ack));
  endtask

  task automatic cfg_write(input int addr, input logic [31:0] wdata);
    logic [31:0] unused;
    // newly enabled clients count as enabled before the write lands
    if (addr == 0) tb_mask = tb_mask | wdata[NC-1:0];
    cfg_access(1'b1, addr, wdata, unused);
    if (addr == 0) tb_mask = wdata[NC-1:0];
  endtask

  task automatic cfg_expect(input string name, input int addr, input logic [31:0] exp);
    logic [31:0] rd;
    cfg_access(1'b0, addr, 32'h0, rd);
    check_value(name, exp, rd);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'he458));
    n_checks  = 0;
    n_err     = 0;
    tb_mask   = '1;
    stall_en  = 1'b0;
    mem_rbeat = 0;
    mem_wbeat = 0;
    cfg_req   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    bus_rsp   = '0;
    for (int c = 0; c < NC; c++) begin
      client_req[c]         = '0;
      client_req[c].r_ready = 1'b1;
      client_req[c].b_ready = 1'b1;
      rbeat[c]              = 0;
    end
    arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // state right after reset
    check_value("reset ar_valid", 32'h0, 32'(bus_req.ar_valid));
    check_value("reset aw_valid", 32'h0, 32'(bus_req.aw_valid));
    check_value("reset w_valid", 32'h0, 32'(bus_req.w_valid));
    check_value("reset cfg_ack", 32'h0, 32'(cfg_ack));
    for (int c = 0; c < NC; c++) begin
      check_value("reset r_valid", 32'h0, 32'(client_rsp[c].r_valid));
      check_value("reset b_valid", 32'h0, 32'(client_rsp[c].b_valid));
    end

    // configuration registers
    cfg_expect("cfg mask reset", 0, 32'h7);
    cfg_expect("cfg mode reset", 1, 32'h0);
    cfg_write(0, 32'h5);
    cfg_expect("cfg mask", 0, 32'h5);
    cfg_write(1, 32'h1);
    cfg_expect("cfg mode", 1, 32'h1);
    cfg_write(2, 32'hffff_ffff);
    cfg_expect("cfg mask kept", 0, 32'h5);
    cfg_expect("cfg unused 2", 2, 32'h0);
    cfg_expect("cfg unused 3", 3, 32'h0);
    cfg_write(0, 32'h7);
    cfg_write(1, 32'h0);

    // fixed priority with all three requesting at once
    ar_log.delete();
    fork
      do_read(0, 0, 1'b0);
      do_read(1, 0, 1'b0);
      do_read(2, 0, 1'b0);
    join
    check_value("fixed grants", 32'h3, 32'(ar_log.size()));
    for (int k = 0; k < ar_log.size() && k < 3; k++) begin
      check_value("fixed grant order", 32'(2 - k), 32'(ar_log[k]));
    end

    // round robin with requests held continuously
    cfg_write(1, 32'h1);
    ar_log.delete();
    fork
      begin do_read(0, 0, 1'b1); do_read(0, 0, 1'b1); do_read(0, 0, 1'b0); end
      begin do_read(1, 0, 1'b1); do_read(1, 0, 1'b1); do_read(1, 0, 1'b0); end
      begin do_read(2, 0, 1'b1); do_read(2, 0, 1'b1); do_read(2, 0, 1'b0); end
    join
    check_value("rr grants", 32'd9, 32'(ar_log.size()));
    for (int k = 1; k < ar_log.size(); k++) begin
      check_value("rr rotation", 32'((ar_log[k-1] + 1) % 3), 32'(ar_log[k]));
    end
    cfg_write(1, 32'h0);

    // fetch disabled while it requests, then re-enabled
    stall_en = 1'b1;
    cfg_write(0, 32'h6);
    fork
      do_read(0, 3, 1'b0);
      do_write(0, 2);
      begin
        repeat (20) @(posedge clk_i);
        check_value("disabled read pending", 32'h0, 32'(rexp[0].size()));
        cfg_write(0, 32'h7);
      end
    join

    // random concurrent traffic under bus stalls
    fork
      run_client(0, RAND_OPS);
      run_client(1, RAND_OPS);
      run_client(2, RAND_OPS);
    join

    // drain outstanding responses
    while (ar_q.size() > 0 || b_q.size() > 0 || aw_pend.size() > 0 ||
           rexp[0].size() > 0 || rexp[1].size() > 0 || rexp[2].size() > 0 ||
           bexp[0].size() > 0 || bexp[1].size() > 0 || bexp[2].size() > 0) begin
      @(posedge clk_i);
    end
    for (int c = 0; c < NC; c++) begin
      check_value("w data left", 32'h0, 32'(wexp[c].size()));
    end

    $display("checks %0d, errors %0d", n_checks, n_err);
    if (n_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: list.f
src/mem_port_pkg.sv
src/port_cfg_regs.sv
src/addr_arbiter.sv
src/wdata_order_fifo.sv
src/rsp_router.sv
src/mem_port_mux.sv
test/tb_mem_port_mux.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory-port combiner testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_mem_port_mux \
  -f list.f \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi
